/* Bender.yml */
package:
  name: aes_wb

export_include_dirs:
  - include

sources:
  - verilog/aes_types_pkg.sv
  - verilog/aes_math_pkg.sv
  - verilog/aes_ctrl_if.sv
  - verilog/aes_regs.sv
  - verilog/mod_enc_shifter.sv
  - verilog/aes_round_core.sv
  - verilog/aes_top.sv
  - target: test
    files:
      - test/aes_tb.sv

/* filelist.f */
+incdir+include
verilog/aes_types_pkg.sv
verilog/aes_math_pkg.sv
verilog/aes_ctrl_if.sv
verilog/aes_regs.sv
verilog/mod_enc_shifter.sv
verilog/aes_round_core.sv
verilog/aes_top.sv
test/aes_tb.sv

/* include/aes_defs.svh */
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// Cipher geometry for AES-128.
`define AES_ROUNDS      10   // Number of cipher rounds for a 128-bit key.
`define AES_BLOCK_BYTES 16   // Bytes in one state block.

// Wishbone bus geometry.
`define AES_WB_AW       4    // Word address width, covers 16 registers.
`define AES_WB_DW       32   // Data width, one full word per access.

// The block is carried as four bus words.
// Byte 0 of the block sits in the most significant byte of word 0.
// This matches the FIPS-197 column-major input order.
// The bus side and the core side both rely on that layout.
// Changing AES_WB_DW breaks the four-word key, din and dout mapping.

`endif

/* test/aes_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_defs.svh"

module aes_tb;

  logic                  clk;
  logic                  resetn;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`AES_WB_AW-1:0] wb_adr;
  logic [`AES_WB_DW-1:0] wb_dat_w;
  wire  [`AES_WB_DW-1:0] wb_dat_r;
  wire                   wb_ack;

  integer       seed;            // State of the $random sequence.
  int           req_count;       // Bus requests issued by the tasks.
  int           ack_count;       // Acks seen on the bus.
  logic [7:0]   sbox_tab [256];  // Forward S-box built from GF(2^8) arithmetic.
  logic [127:0] key_a;
  logic [127:0] pt_a;
  logic [127:0] key_b;
  logic [127:0] pt_b;
  logic [31:0]  rd;

  aes_top aes_top_inst (
    .clk      (clk),
    .resetn   (resetn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #20 clk = ~clk;  // 40 ns period.

  always @(negedge clk)
  begin
    if (wb_ack === 1'b1)
      ack_count++;  // Sampled mid-cycle, away from the edge.
  end

  task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                       input string msg);
    if (actual !== expected)
    begin
      $display("Error: %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  // Carry-less product reduced by the AES polynomial.
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ a;
      a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h00;  // Zero maps to zero by definition.
    for (int x = 1; x < 256; x++)
      if (gf_mul(a, x[7:0]) == 8'h01)
        r = x[7:0];
    return r;
  endfunction

  function automatic logic [7:0] rotl8(input logic [7:0] b, input int k);
    return (b << k) | (b >> (8 - k));
  endfunction

  task automatic build_sbox;
    logic [7:0] v;
    for (int i = 0; i < 256; i++)
    begin
      v = gf_inv(i[7:0]);
      sbox_tab[i] = v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
    end
  endtask

  // Reference cipher; s[4c+r] holds row r, column c.
  function automatic logic [127:0] aes128_encrypt(input logic [127:0] key,
                                                  input logic [127:0] pt);
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [31:0]  w [44];
    logic [31:0]  tmp;
    logic [7:0]   rc;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;
    logic [127:0] out;
    rc = 8'h01;
    for (int i = 0; i < 4; i++)
      w[i] = key[127-32*i -: 32];
    for (int i = 4; i < 44; i++)
    begin
      tmp = w[i-1];
      if (i % 4 == 0)
      begin
        tmp = {sbox_tab[tmp[23:16]], sbox_tab[tmp[15:8]], sbox_tab[tmp[7:0]],
               sbox_tab[tmp[31:24]]} ^ {rc, 24'h0};  // RotWord, SubWord, Rcon.
        rc = gf_mul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int i = 0; i < 16; i++)
      s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];  // Initial AddRoundKey.
    for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++)
    begin
      for (int r = 0; r < 4; r++)
        for (int c = 0; c < 4; c++)
          t[4*c+r] = sbox_tab[s[4*((c+r)%4)+r]];  // SubBytes then ShiftRows.
      for (int c = 0; c < 4; c++)
      begin
        a0 = t[4*c];
        a1 = t[4*c+1];
        a2 = t[4*c+2];
        a3 = t[4*c+3];
        if (rnd == `AES_ROUNDS)
        begin
          s[4*c]   = a0;  // The last round has no MixColumns.
          s[4*c+1] = a1;
          s[4*c+2] = a2;
          s[4*c+3] = a3;
        end
        else
        begin
          s[4*c]   = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
          s[4*c+1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
          s[4*c+2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
          s[4*c+3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
        end
        for (int r = 0; r < 4; r++)
          s[4*c+r] = s[4*c+r] ^ w[4*rnd+c][31-8*r -: 8];
      end
    end
    for (int i = 0; i < 16; i++)
      out[127-8*i -: 8] = s[i];
    return out;
  endfunction

  // Called 1 ns after a rising edge, returns at the same point of a later cycle.
  task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
    int n;
    n = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    req_count++;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!wb_ack && n < 16);
    if (!wb_ack)
    begin
      $display("Write to address %0d was never acknowledged.", adr);
      $display("Result: FAILED");
      $fatal(1);
    end
    check(n, 1, "write ack latency");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #1;
    check(wb_ack, 1'b0, "ack gap after write");
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
    int n;
    n = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    req_count++;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!wb_ack && n < 16);
    if (!wb_ack)
    begin
      $display("Read from address %0d was never acknowledged.", adr);
      $display("Result: FAILED");
      $fatal(1);
    end
    check(n, 1, "read ack latency");
    data   = wb_dat_r;  // Valid while ack is high.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(posedge clk);
    #1;
    check(wb_ack, 1'b0, "ack gap after read");
  endtask

  task automatic write_block(input logic [3:0] base, input logic [127:0] blk);
    for (int i = 0; i < 4; i++)
      wb_write(base + i[3:0], blk[127-32*i -: 32]);  // Word 0 carries bytes 0 to 3.
  endtask

  task automatic verify_block(input logic [3:0] base, input logic [127:0] expected,
                              input string msg);
    logic [31:0] word;
    for (int i = 0; i < 4; i++)
    begin
      wb_read(base + i[3:0], word);
      check(word, expected[127-32*i -: 32], $sformatf("%s word %0d", msg, i));
    end
  endtask

  task automatic rand_block(output logic [127:0] blk);
    for (int i = 0; i < 4; i++)
      blk[127-32*i -: 32] = $random(seed);
  endtask

  task automatic wait_done;
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < 400)
    begin
      wb_read(aes_types_pkg::reg_status, status);
      polls++;
    end
    if (!status[1])
    begin
      $display("The core did not report done within 400 status polls.");
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic run_block(input logic [127:0] key, input logic [127:0] pt,
                           input logic [127:0] expected, input string msg);
    logic [31:0] status;
    write_block(aes_types_pkg::reg_key0, key);
    write_block(aes_types_pkg::reg_din0, pt);
    wb_write(aes_types_pkg::reg_ctrl, 32'h1);
    wait_done;
    wb_read(aes_types_pkg::reg_status, status);
    check(status, 32'h2, {msg, " status"});  // Done set, busy clear.
    verify_block(aes_types_pkg::reg_dout0, expected, {msg, " ciphertext"});
  endtask

  initial
  begin
    clk       = 1'b0;
    resetn    = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    seed      = 32'h99fca53e;
    req_count = 0;
    ack_count = 0;
    build_sbox;
    check(sbox_tab[8'h53], 8'hed, "computed S-box entry 53");
    check(aes128_encrypt(128'h000102030405060708090a0b0c0d0e0f,
                         128'h00112233445566778899aabbccddeeff),
          128'h69c4e0d86a7b0430d8cdb78070b4c55a, "model known answer");

    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;

    // Reset state, with no request on the bus yet.
    repeat (3)
    begin
      @(posedge clk);
      #1;
      check(wb_ack, 1'b0, "ack idle after reset");
    end
    wb_read(aes_types_pkg::reg_status, rd);
    check(rd, 32'h0, "status after reset");
    verify_block(aes_types_pkg::reg_dout0, 128'h0, "dout after reset");

    run_block(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff,
              128'h69c4e0d86a7b0430d8cdb78070b4c55a, "known answer");

    for (int i = 0; i < 20; i++)
    begin
      rand_block(key_a);
      rand_block(pt_a);
      run_block(key_a, pt_a, aes128_encrypt(key_a, pt_a), $sformatf("random block %0d", i));
    end

    // Readback, then a new start must clear the sticky done bit.
    rand_block(key_a);
    rand_block(pt_a);
    write_block(aes_types_pkg::reg_key0, key_a);
    write_block(aes_types_pkg::reg_din0, pt_a);
    verify_block(aes_types_pkg::reg_key0, key_a, "key readback");
    verify_block(aes_types_pkg::reg_din0, pt_a, "din readback");
    wb_write(aes_types_pkg::reg_ctrl, 32'h1);
    wb_read(aes_types_pkg::reg_status, rd);
    check(rd, 32'h1, "status after new start");  // Busy, done cleared.
    wait_done;
    verify_block(aes_types_pkg::reg_dout0, aes128_encrypt(key_a, pt_a), "readback ciphertext");

    // Writes while busy must not disturb the block in flight.
    rand_block(key_a);
    rand_block(pt_a);
    rand_block(key_b);
    rand_block(pt_b);
    write_block(aes_types_pkg::reg_key0, key_a);
    write_block(aes_types_pkg::reg_din0, pt_a);
    wb_write(aes_types_pkg::reg_ctrl, 32'h1);
    wb_read(aes_types_pkg::reg_status, rd);
    check(rd[0], 1'b1, "busy after start");
    write_block(aes_types_pkg::reg_key0, key_b);
    write_block(aes_types_pkg::reg_din0, pt_b);
    wb_write(aes_types_pkg::reg_ctrl, 32'h1);
    wb_read(aes_types_pkg::reg_status, rd);
    check(rd[0], 1'b1, "still busy after ignored writes");
    wait_done;
    verify_block(aes_types_pkg::reg_dout0, aes128_encrypt(key_a, pt_a), "busy-write ciphertext");
    verify_block(aes_types_pkg::reg_key0, key_a, "key kept while busy");
    verify_block(aes_types_pkg::reg_din0, pt_a, "din kept while busy");

    @(posedge clk);
    #1;
    check(ack_count, req_count, "one ack per request");

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/aes_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface aes_ctrl_if;

  aes_types_pkg::aes_block_t key;        // Cipher key from the register block.
  aes_types_pkg::aes_block_t block_in;   // Plaintext block.
  logic                      start;      // One-clock request, only sent while idle.
  logic                      busy;       // Core is working on a block.
  logic                      done;       // One-clock completion pulse.
  aes_types_pkg::aes_block_t block_out;  // Ciphertext, valid with done.

  modport regs (output key, output block_in, output start,
                input busy, input done, input block_out);

  modport core (input key, input block_in, input start,
                output busy, output done, output block_out);

endinterface

`default_nettype wire

/* verilog/aes_math_pkg.sv */
`default_nettype none

package aes_math_pkg;

  // Forward S-box, entry 0 in the top byte.
  localparam logic [2047:0] sbox_lut = {
    128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] sbox(input logic [7:0] b);
    return sbox_lut[2047-8*b -: 8];  // Top byte is entry 0.
  endfunction

  // Multiply by x in GF(2^8) modulo x^8+x^4+x^3+x+1.
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // One column of MixColumns, byte a0 in bits 31:24.
  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,    // 2 3 1 1.
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,    // 1 2 3 1.
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,    // 1 1 2 3.
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};   // 3 1 1 2.
  endfunction

  // Round constants are successive powers of x, so 0x80 wraps to 0x1b.
  function automatic logic [7:0] next_rcon(input logic [7:0] rc);
    return xtime(rc);
  endfunction

endpackage

`default_nettype wire

/* verilog/aes_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_defs.svh"

module aes_regs (
  input  wire                   clk,
  input  wire                   resetn,
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire  [`AES_WB_AW-1:0] wb_adr,
  input  wire  [`AES_WB_DW-1:0] wb_dat_w,
  output logic [`AES_WB_DW-1:0] wb_dat_r,
  output logic                  wb_ack,
  aes_ctrl_if.regs              ctl
);

  aes_types_pkg::aes_reg_e    adr_e;      // Decoded word address.
  logic                       req;        // New request, not yet acknowledged.
  logic                       wr_acc;     // Write accepted on this edge.
  logic                       wr_ok;      // Accepted write that may change state.
  logic [0:3][`AES_WB_DW-1:0] key_w;      // Word 0 holds key bytes 0 to 3.
  logic [0:3][`AES_WB_DW-1:0] din_w;      // Plaintext words, same order.
  logic [0:3][`AES_WB_DW-1:0] dout_w;     // Ciphertext words, same order.
  logic                       done_flag;  // Sticky completion flag.
  logic [`AES_WB_DW-1:0]      rd_mux;

  assign req    = wb_cyc && wb_stb && !wb_ack;  // The ack cycle itself is never a new request.
  assign wr_acc = req && wb_we;
  assign wr_ok  = wr_acc && !ctl.busy;          // Writes land only while the core is idle.
  assign adr_e  = aes_types_pkg::aes_reg_e'(wb_adr);

  assign ctl.key      = key_w;   // Word order already matches block byte order.
  assign ctl.block_in = din_w;

  // Control state and the result words.
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      wb_ack    <= 1'b0;
      ctl.start <= 1'b0;
      done_flag <= 1'b0;
      dout_w    <= '0;  // Result reads zero until the first block completes.
    end
    else
    begin
      wb_ack    <= req;  // One ack, then a forced gap.
      ctl.start <= wr_ok && (adr_e == aes_types_pkg::reg_ctrl) && wb_dat_w[0];
      if (ctl.done)
      begin
        done_flag <= 1'b1;
        dout_w    <= ctl.block_out;  // Capture the result with the done pulse.
      end
      else if (ctl.start)
        done_flag <= 1'b0;  // A new block clears the previous completion.
    end
  end

  // Key and plaintext words, plus the read data register.
  always_ff @(posedge clk)
  begin
    if (wr_ok)
    begin
      case (adr_e)
        aes_types_pkg::reg_key0, aes_types_pkg::reg_key1,
        aes_types_pkg::reg_key2, aes_types_pkg::reg_key3:
          key_w[wb_adr[1:0]] <= wb_dat_w;  // Low address bits pick the word.
        aes_types_pkg::reg_din0, aes_types_pkg::reg_din1,
        aes_types_pkg::reg_din2, aes_types_pkg::reg_din3:
          din_w[wb_adr[1:0]] <= wb_dat_w;
        default: ;  // ctrl only produces the start pulse.
      endcase
    end
    if (req && !wb_we)
      wb_dat_r <= rd_mux;  // Held through the ack cycle.
  end

  always_comb
  begin
    case (adr_e)
      aes_types_pkg::reg_status:
        rd_mux = {{(`AES_WB_DW-2){1'b0}}, done_flag, ctl.busy};
      aes_types_pkg::reg_key0, aes_types_pkg::reg_key1,
      aes_types_pkg::reg_key2, aes_types_pkg::reg_key3:
        rd_mux = key_w[wb_adr[1:0]];
      aes_types_pkg::reg_din0, aes_types_pkg::reg_din1,
      aes_types_pkg::reg_din2, aes_types_pkg::reg_din3:
        rd_mux = din_w[wb_adr[1:0]];
      aes_types_pkg::reg_dout0, aes_types_pkg::reg_dout1,
      aes_types_pkg::reg_dout2, aes_types_pkg::reg_dout3:
        rd_mux = dout_w[wb_adr[1:0]];
      default:
        rd_mux = '0;  // ctrl and the unmapped words read as zero.
    endcase
  end

endmodule

`default_nettype wire

/* verilog/aes_round_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_defs.svh"

module aes_round_core (
  input wire       clk,
  input wire       resetn,
  aes_ctrl_if.core ctl
);

  localparam int rw = $clog2(`AES_ROUNDS+1);

  aes_types_pkg::aes_state_e               fsm;
  logic [rw-1:0]                           round;       // Current round, 1 to 10.
  aes_types_pkg::aes_block_t               st;          // State held in row-major order.
  aes_types_pkg::aes_block_t               rk;          // Key of the previous round.
  logic [7:0]                              rcon;        // Round constant for the next key.
  logic                                    wr_en;
  logic [7:0]                              inp_shf;
  logic [`AES_BLOCK_BYTES-1:0][7:0]        shf_out;
  logic                                    block_full;
  aes_types_pkg::aes_block_t               sr_cols;     // ShiftRows result, column-major.
  aes_types_pkg::aes_block_t               next_key;    // Key for the round being finished.
  aes_types_pkg::aes_block_t               new_cols;    // State after AddRoundKey.
  logic [31:0]                             key_tmp;     // SubWord(RotWord(w3)) ^ rcon.

  // Swaps row-major and column-major byte order; a 4x4 transpose is its own inverse.
  function automatic aes_types_pkg::aes_block_t transpose(input aes_types_pkg::aes_block_t b);
    aes_types_pkg::aes_block_t t;
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        t[127-8*(4*c+r) -: 8] = b[127-8*(4*r+c) -: 8];
    return t;
  endfunction

  mod_enc_shifter shifter_inst (
    .clk        (clk),
    .resetn     (resetn),
    .wr_en      (wr_en),
    .inp_shf    (inp_shf),
    .outp_shf   (shf_out),
    .block_full (block_full)
  );

  assign wr_en   = (fsm == aes_types_pkg::st_sub_feed);
  assign inp_shf = aes_math_pkg::sbox(st[127:120]);  // SubBytes on the byte at the head.

  assign ctl.busy      = (fsm != aes_types_pkg::st_idle);
  assign ctl.done      = (fsm == aes_types_pkg::st_finish);
  assign ctl.block_out = transpose(st);  // Back to FIPS-197 byte order.

  // Key schedule step for AES-128.
  always_comb
  begin
    key_tmp = {aes_math_pkg::sbox(rk[23:16]), aes_math_pkg::sbox(rk[15:8]),
               aes_math_pkg::sbox(rk[7:0]), aes_math_pkg::sbox(rk[31:24])} ^ {rcon, 24'h0};
    next_key[127:96] = rk[127:96] ^ key_tmp;
    next_key[95:64]  = rk[95:64]  ^ next_key[127:96];
    next_key[63:32]  = rk[63:32]  ^ next_key[95:64];
    next_key[31:0]   = rk[31:0]   ^ next_key[63:32];
  end

  // Shifter output is row-major, MixColumns wants columns.
  always_comb
  begin
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        sr_cols[127-8*(4*c+r) -: 8] = shf_out[4*r+c];
  end

  always_comb
  begin
    for (int j = 0; j < 4; j++)
    begin
      if (round == rw'(`AES_ROUNDS))
        new_cols[127-32*j -: 32] = sr_cols[127-32*j -: 32] ^ next_key[127-32*j -: 32];
      else
        new_cols[127-32*j -: 32] = aes_math_pkg::mix_column(sr_cols[127-32*j -: 32]) ^
                                   next_key[127-32*j -: 32];
    end
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      fsm   <= aes_types_pkg::st_idle;
      round <= '0;
    end
    else
    begin
      case (fsm)
        aes_types_pkg::st_idle:
          if (ctl.start)
          begin
            fsm   <= aes_types_pkg::st_sub_feed;
            round <= rw'(1);
          end
        aes_types_pkg::st_sub_feed:
          if (block_full)
            fsm <= aes_types_pkg::st_mix_add;  // Shifter output is ready next cycle.
        aes_types_pkg::st_mix_add:
          if (round == rw'(`AES_ROUNDS))
            fsm <= aes_types_pkg::st_finish;
          else
          begin
            round <= round + 1'b1;
            fsm   <= aes_types_pkg::st_sub_feed;
          end
        default:
          fsm <= aes_types_pkg::st_idle;  // finish lasts one cycle.
      endcase
    end
  end

  // Datapath registers, loaded on start and updated per round.
  always_ff @(posedge clk)
  begin
    case (fsm)
      aes_types_pkg::st_idle:
        if (ctl.start)
        begin
          st   <= transpose(ctl.block_in ^ ctl.key);  // Initial AddRoundKey.
          rk   <= ctl.key;
          rcon <= 8'h01;
        end
      aes_types_pkg::st_sub_feed:
        st <= {st[119:0], st[127:120]};  // Rotate, so the state is whole again after 16.
      aes_types_pkg::st_mix_add:
      begin
        st   <= transpose(new_cols);
        rk   <= next_key;
        rcon <= aes_math_pkg::next_rcon(rcon);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/aes_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_defs.svh"

module aes_top (
  input  wire                   clk,
  input  wire                   resetn,
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire  [`AES_WB_AW-1:0] wb_adr,
  input  wire  [`AES_WB_DW-1:0] wb_dat_w,
  output logic [`AES_WB_DW-1:0] wb_dat_r,
  output logic                  wb_ack
);

  aes_ctrl_if ctl_if ();  // Register block to core link.

  aes_regs regs_inst (
    .clk      (clk),
    .resetn   (resetn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .ctl      (ctl_if.regs)
  );

  aes_round_core core_inst (
    .clk    (clk),
    .resetn (resetn),
    .ctl    (ctl_if.core)
  );

endmodule

`default_nettype wire

/* verilog/aes_types_pkg.sv */
`default_nettype none

`include "aes_defs.svh"

package aes_types_pkg;

  // One cipher block, byte 0 in bits 127:120.
  typedef logic [`AES_BLOCK_BYTES*8-1:0] aes_block_t;

  typedef enum logic [1:0] {
    st_idle,      // Waiting for a start pulse.
    st_sub_feed,  // Streaming substituted bytes into the shifter.
    st_mix_add,   // MixColumns, AddRoundKey and key schedule step.
    st_finish     // Result valid, done pulse.
  } aes_state_e;

  // Register map, decoded from the word address.
  typedef enum logic [`AES_WB_AW-1:0] {
    reg_ctrl   = 4'd0,  reg_status = 4'd1,
    reg_key0   = 4'd4,  reg_key1   = 4'd5,  reg_key2  = 4'd6,  reg_key3  = 4'd7,
    reg_din0   = 4'd8,  reg_din1   = 4'd9,  reg_din2  = 4'd10, reg_din3  = 4'd11,
    reg_dout0  = 4'd12, reg_dout1  = 4'd13, reg_dout2 = 4'd14, reg_dout3 = 4'd15
  } aes_reg_e;

endpackage

`default_nettype wire

/* verilog/mod_enc_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "aes_defs.svh"

module mod_enc_shifter (
  input  wire                              clk,
  input  wire                              resetn,
  input  wire                              wr_en,
  input  wire  [7:0]                       inp_shf,
  output logic [`AES_BLOCK_BYTES-1:0][7:0] outp_shf,
  output logic                             block_full
);

  localparam int n = `AES_BLOCK_BYTES;

  logic [n-1:0][7:0]       aux;      // Index 4r+c holds row r, column c after a full load.
  logic [$clog2(n)-1:0]    counter;  // Writes seen in the current block.

  // Shift toward index 0, new byte enters at the top.
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < n-1; i++)
        aux[i] <= aux[i+1];
      aux[n-1] <= inp_shf;
    end
  end

  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      counter <= '0;
    else if (wr_en)
    begin
      if (counter == n-1)
        counter <= '0;  // Wrap at the block boundary.
      else
        counter <= counter + 1'b1;
    end
  end

  assign block_full = wr_en && (counter == n-1);  // Sixteenth write is being clocked.

  // ShiftRows rotates row r left by r positions.
  always_comb
  begin
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        outp_shf[4*r+c] = aux[4*r + ((c+r) % 4)];
  end

endmodule

`default_nettype wire
